// ==== axi_fifo_bridge.f ====
+incdir+verif
source/axi_fifo_pkg.sv
source/axi_write_channel.sv
source/axi_read_channel.sv
source/axi_fifo_bridge.sv
verif/axi_fifo_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f axi_fifo_bridge.f --top-module axi_fifo_bridge_tb \
    -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Result: FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"

// ==== source/axi_fifo_bridge.sv ====
`timescale 1ns/1ns

module axi_fifo_bridge
    import axi_fifo_pkg::*;
#(
    parameter int fifo_count_width = 10
) (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    // Write address
    input  logic [addr_width-1:0]       s_axi_awaddr,
    input  logic [id_width-1:0]         s_axi_awid,
    input  logic [7:0]                  s_axi_awlen,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    // Write data, wlast ends the burst
    input  logic [data_width-1:0]       s_axi_wdata,
    input  logic                        s_axi_wvalid,
    input  logic                        s_axi_wlast,
    output logic                        s_axi_wready,
    // Write response
    input  logic                        s_axi_bready,
    output logic                        s_axi_bvalid,
    output logic [1:0]                  s_axi_bresp,
    output logic [id_width-1:0]         s_axi_bid,
    // Read address
    input  logic [addr_width-1:0]       s_axi_araddr,
    input  logic [id_width-1:0]         s_axi_arid,
    input  logic [7:0]                  s_axi_arlen,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    // Read data
    input  logic                        s_axi_rready,
    output logic                        s_axi_rvalid,
    output logic [data_width-1:0]       s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rlast,
    output logic [id_width-1:0]         s_axi_rid,
    // rto core, filled by the bridge
    output logic                        rto_core_reset,
    output logic                        rto_core_flush,
    output logic                        rto_core_write,
    output logic [data_width-1:0]       rto_core_fifo_din,
    input  logic                        rto_core_full,
    // rti core, FWFT, drained by the bridge
    output logic                        rti_core_reset,
    output logic                        rti_core_flush,
    output logic                        rti_core_rd_en,
    input  logic [data_width-1:0]       rti_core_fifo_dout,
    input  logic                        rti_core_empty,
    input  logic [fifo_count_width-1:0] data_num
);

    // Write side, awlen unused since wlast closes the burst
    axi_write_channel axi_write_channel_i (
        .s_axi_aclk        (s_axi_aclk),
        .s_axi_aresetn     (s_axi_aresetn),
        .awaddr            (s_axi_awaddr),
        .awid              (s_axi_awid),
        .awvalid           (s_axi_awvalid),
        .awready           (s_axi_awready),
        .wdata             (s_axi_wdata),
        .wvalid            (s_axi_wvalid),
        .wlast             (s_axi_wlast),
        .wready            (s_axi_wready),
        .bready            (s_axi_bready),
        .bvalid            (s_axi_bvalid),
        .bresp             (s_axi_bresp),
        .bid               (s_axi_bid),
        .rto_core_full     (rto_core_full),
        .rto_core_write    (rto_core_write),
        .rto_core_fifo_din (rto_core_fifo_din),
        .rto_core_flush    (rto_core_flush),
        .rti_core_flush    (rti_core_flush),
        .rto_core_reset    (rto_core_reset),
        .rti_core_reset    (rti_core_reset)
    );

    // Read side
    axi_read_channel #(
        .fifo_count_width (fifo_count_width)
    ) axi_read_channel_i (
        .s_axi_aclk         (s_axi_aclk),
        .s_axi_aresetn      (s_axi_aresetn),
        .araddr             (s_axi_araddr),
        .arid               (s_axi_arid),
        .arlen              (s_axi_arlen),
        .arvalid            (s_axi_arvalid),
        .arready            (s_axi_arready),
        .rready             (s_axi_rready),
        .rvalid             (s_axi_rvalid),
        .rdata              (s_axi_rdata),
        .rresp              (s_axi_rresp),
        .rlast              (s_axi_rlast),
        .rid                (s_axi_rid),
        .rti_core_fifo_dout (rti_core_fifo_dout),
        .rti_core_empty     (rti_core_empty),
        .data_num           (data_num),
        .rti_core_rd_en     (rti_core_rd_en)
    );

endmodule

// ==== source/axi_fifo_pkg.sv ====
package axi_fifo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    // Two map addresses need 5 bits, one spare
    localparam int addr_width = 6;
    localparam int data_width = 128;
    localparam int id_width   = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // FIFO data window, push on write and pop on read
    localparam logic [addr_width-1:0] fifo_addr = 6'h00;
    // Flush command on write, fill count on read
    localparam logic [addr_width-1:0] ctrl_addr = 6'h10;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    ////////////////////////////////////////////////////////////////////////////
    // Channel FSM states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        w_idle,
        w_fifo_data,
        w_flush_data,
        w_discard_data,
        w_response
    } write_state_t;

    typedef enum logic [1:0] {
        r_idle,
        r_fifo_data,
        r_count_data,
        r_error_data
    } read_state_t;

    // Write beat seen as rto payload or as flush command
    typedef union packed {
        logic [data_width-1:0] payload;
        struct packed {
            logic [data_width-3:0] reserved;
            logic                  rti_flush;
            logic                  rto_flush;
        } cmd;
    } write_word_u;

endpackage

// ==== source/axi_read_channel.sv ====
`timescale 1ns/1ns

module axi_read_channel
    import axi_fifo_pkg::*;
#(
    parameter int fifo_count_width = 10
) (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [addr_width-1:0]       araddr,
    input  logic [id_width-1:0]         arid,
    input  logic [7:0]                  arlen,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic                        rready,
    output logic                        rvalid,
    output logic [data_width-1:0]       rdata,
    output logic [1:0]                  rresp,
    output logic                        rlast,
    output logic [id_width-1:0]         rid,
    input  logic [data_width-1:0]       rti_core_fifo_dout,
    input  logic                        rti_core_empty,
    input  logic [fifo_count_width-1:0] data_num,
    output logic                        rti_core_rd_en
);

    read_state_t           state;
    logic [7:0]            beats_left;
    logic [data_width-1:0] rdata_q;
    logic                  hold_err;
    logic                  beat_err;
    logic                  r_beat;

    ////////////////////////////////////////////////////////////////////////////
    // Beat presentation
    ////////////////////////////////////////////////////////////////////////////

    assign arready = (state == r_idle);
    assign rvalid  = (state != r_idle);
    assign r_beat  = rvalid && rready;

    // Empty FIFO fails the beat
    // Once shown stalled, the error stays until taken
    assign beat_err = rti_core_empty || hold_err;

    // FWFT dout goes straight out on good FIFO beats
    assign rdata = ((state == r_fifo_data) && !beat_err) ? rti_core_fifo_dout : rdata_q;

    always_comb begin
        case (state)
            r_fifo_data:  rresp = beat_err ? resp_slverr : resp_okay;
            r_count_data: rresp = resp_okay;
            default:      rresp = resp_slverr;
        endcase
    end

    // Count and error reads are single beats
    assign rlast = (state == r_fifo_data) ? (beats_left == 8'd0) : (state != r_idle);

    // Pop on the same cycle an okay beat is taken
    assign rti_core_rd_en = (state == r_fifo_data) && r_beat && !beat_err;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state    <= r_idle;
            hold_err <= 1'b0;
        end else begin
            case (state)
                r_idle: begin
                    hold_err <= 1'b0;
                    if (arvalid) begin
                        case (araddr)
                            fifo_addr: state <= r_fifo_data;
                            ctrl_addr: state <= r_count_data;
                            default:   state <= r_error_data;
                        endcase
                    end
                end
                r_fifo_data: begin
                    if (r_beat) begin
                        hold_err <= 1'b0;
                        if (beats_left == 8'd0) begin
                            state <= r_idle;
                        end
                    end else if (rti_core_empty) begin
                        hold_err <= 1'b1;
                    end
                end
                default: begin
                    if (r_beat) begin
                        state <= r_idle;
                    end
                end
            endcase
        end
    end

    // Beat counter, ID and count snapshot set at address time
    always_ff @(posedge s_axi_aclk) begin
        if (arvalid && arready) begin
            beats_left <= arlen;
            rid        <= arid;
            if (araddr == ctrl_addr) begin
                rdata_q <= data_width'(data_num);
            end else begin
                rdata_q <= '0;
            end
        end else if ((state == r_fifo_data) && r_beat) begin
            beats_left <= beats_left - 8'd1;
        end
    end

endmodule

// ==== source/axi_write_channel.sv ====
`timescale 1ns/1ns

module axi_write_channel
    import axi_fifo_pkg::*;
(
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  logic [addr_width-1:0] awaddr,
    input  logic [id_width-1:0]   awid,
    input  logic                  awvalid,
    output logic                  awready,
    input  write_word_u           wdata,
    input  logic                  wvalid,
    input  logic                  wlast,
    output logic                  wready,
    input  logic                  bready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    output logic [id_width-1:0]   bid,
    input  logic                  rto_core_full,
    output logic                  rto_core_write,
    output logic [data_width-1:0] rto_core_fifo_din,
    output logic                  rto_core_flush,
    output logic                  rti_core_flush,
    output logic                  rto_core_reset,
    output logic                  rti_core_reset
);

    write_state_t state;
    logic         aw_beat;
    logic         w_beat;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////

    // One transaction at a time
    assign awready = (state == w_idle);

    // rto back-pressure stalls payload beats only
    // Flush and discard beats always drain
    assign wready = ((state == w_fifo_data) && !rto_core_full)
                  || (state == w_flush_data)
                  || (state == w_discard_data);

    assign aw_beat = awvalid && awready;
    assign w_beat  = wvalid && wready;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state          <= w_idle;
            bvalid         <= 1'b0;
            rto_core_write <= 1'b0;
            rto_core_flush <= 1'b0;
            rti_core_flush <= 1'b0;
        end else begin
            // Push and flush are single-cycle pulses
            rto_core_write <= 1'b0;
            rto_core_flush <= 1'b0;
            rti_core_flush <= 1'b0;

            case (state)
                w_idle: begin
                    // Address decode picks the data state
                    if (aw_beat) begin
                        case (awaddr)
                            fifo_addr: state <= w_fifo_data;
                            ctrl_addr: state <= w_flush_data;
                            default:   state <= w_discard_data;
                        endcase
                    end
                end
                w_fifo_data: begin
                    if (w_beat) begin
                        rto_core_write <= 1'b1;
                    end
                end
                w_flush_data: begin
                    // Each flush bit drives its own core
                    if (w_beat) begin
                        rto_core_flush <= wdata.cmd.rto_flush;
                        rti_core_flush <= wdata.cmd.rti_flush;
                    end
                end
                w_response: begin
                    // Hold bvalid until the master takes it
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= w_idle;
                    end
                end
                default: begin
                    // Discard state only waits for wlast
                end
            endcase

            // Last beat of any data state raises the response
            if (w_beat && wlast) begin
                state  <= w_response;
                bvalid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response and payload registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        // ID and response code fixed at address time
        if (aw_beat) begin
            bid <= awid;
            if ((awaddr == fifo_addr) || (awaddr == ctrl_addr)) begin
                bresp <= resp_okay;
            end else begin
                bresp <= resp_slverr;
            end
        end
        // Beat data lands with the push pulse
        if ((state == w_fifo_data) && w_beat) begin
            rto_core_fifo_din <= wdata.payload;
        end
    end

    // Core resets follow bus reset, released one cycle late
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rto_core_reset <= 1'b1;
            rti_core_reset <= 1'b1;
        end else begin
            rto_core_reset <= 1'b0;
            rti_core_reset <= 1'b0;
        end
    end

endmodule

// ==== verif/axi_fifo_bridge_tests.svh ====
////////////////////////////////////////////////////////////////////////////
// Bus tasks
////////////////////////////////////////////////////////////////////////////

// Burst of the beats in wr_data, then waits out the response
task automatic write_burst(input logic [addr_width-1:0] addr);
    int   i;
    logic done;
    exp_waddr = addr;
    exp_bid = id_width'($random(seed));
    s_axi_awaddr  <= addr;
    s_axi_awid    <= exp_bid;
    s_axi_awlen   <= 8'(wr_data.size() - 1);
    s_axi_awvalid <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_awready) begin
        @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    s_axi_awvalid <= 1'b0;
    for (i = 0; i < wr_data.size(); i++) begin
        s_axi_wdata  <= wr_data[i];
        s_axi_wvalid <= 1'b1;
        s_axi_wlast  <= (i == wr_data.size() - 1);
        // Hold the beat through back-pressure
        @(negedge s_axi_aclk);
        while (!s_axi_wready) begin
            @(posedge s_axi_aclk);
            @(negedge s_axi_aclk);
        end
        @(posedge s_axi_aclk);
    end
    s_axi_wvalid <= 1'b0;
    s_axi_wlast  <= 1'b0;
    done = 1'b0;
    while (!done) begin
        s_axi_bready <= (($random(seed) % 3) != 0);
        @(negedge s_axi_aclk);
        done = s_axi_bvalid && s_axi_bready;
        @(posedge s_axi_aclk);
    end
    s_axi_bready <= 1'b0;
    // Last push lands a cycle after its beat
    repeat (2) @(posedge s_axi_aclk);
endtask

// Read burst with random rready until rlast is taken
task automatic read_burst(input logic [addr_width-1:0] addr, input int len);
    logic done;
    exp_raddr  = addr;
    exp_rid    = id_width'($random(seed));
    exp_rlen   = len;
    beats_seen = 0;
    s_axi_araddr  <= addr;
    s_axi_arid    <= exp_rid;
    s_axi_arlen   <= 8'(len);
    s_axi_arvalid <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_arready) begin
        @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    s_axi_arvalid <= 1'b0;
    done = 1'b0;
    while (!done) begin
        s_axi_rready <= (($random(seed) % 3) != 0);
        @(negedge s_axi_aclk);
        done = s_axi_rvalid && s_axi_rready && s_axi_rlast;
        @(posedge s_axi_aclk);
    end
    s_axi_rready <= 1'b0;
    // Let the final pop settle in the model
    @(posedge s_axi_aclk);
endtask

// Fill the rti model while the bus is idle
task automatic preload_rti(input int count);
    int i;
    rti_q.delete();
    for (i = 0; i < count; i++) begin
        rti_q.push_back(random_word());
    end
    repeat (2) @(posedge s_axi_aclk);
endtask

////////////////////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////////////////////

task automatic run_tests();
    int n;
    int k;
    int i;
    // Test 1, core resets and idle outputs
    repeat (5) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    @(negedge s_axi_aclk);
    compare("rto_core_reset rti_core_reset", data_width'(2'b11),
            data_width'({rto_core_reset, rti_core_reset}));
    @(negedge s_axi_aclk);
    compare("rto_core_reset rti_core_reset", '0, data_width'({rto_core_reset, rti_core_reset}));
    compare("bvalid rvalid rto_core_write flushes rti_core_rd_en", '0,
            data_width'({s_axi_bvalid, s_axi_rvalid, rto_core_write, rto_core_flush,
                         rti_core_flush, rti_core_rd_en}));
    @(posedge s_axi_aclk);
    $display("Test 1 finished: reset, errors so far %0d", error_count);

    // Test 2, random-length payload bursts
    for (k = 0; k < 3; k++) begin
        n = ($random(seed) & 15) + 1;
        rto_q.delete();
        wr_data.delete();
        for (i = 0; i < n; i++) begin
            wr_data.push_back(random_word());
        end
        write_burst(fifo_addr);
        compare("rto model size", data_width'(n), data_width'(rto_q.size()));
        for (i = 0; (i < n) && (i < rto_q.size()); i++) begin
            compare("rto_core_fifo_din", wr_data[i], rto_q[i]);
        end
    end
    $display("Test 2 finished: write bursts, errors so far %0d", error_count);

    // Test 3, every flush combination, then an unmapped write
    for (k = 0; k < 4; k++) begin
        rto_q.delete();
        rto_q.push_back(random_word());
        rto_q.push_back(random_word());
        preload_rti(3);
        wr_data.delete();
        wr_data.push_back(data_width'(k));
        write_burst(ctrl_addr);
        compare("rto model size", data_width'(k[0] ? 0 : 2), data_width'(rto_q.size()));
        compare("rti model size", data_width'(k[1] ? 0 : 3), data_width'(rti_q.size()));
    end
    rto_q.delete();
    wr_data.delete();
    wr_data.push_back(random_word());
    wr_data.push_back(random_word());
    write_burst(6'h08);
    compare("rto model size", '0, data_width'(rto_q.size()));
    $display("Test 3 finished: flush and unmapped write, errors so far %0d", error_count);

    // Test 4, FIFO read burst leaves two words behind
    n = ($random(seed) & 15) + 1;
    preload_rti(n + 2);
    read_burst(fifo_addr, n - 1);
    compare("read beats", data_width'(n), data_width'(beats_seen));
    compare("rti model size", data_width'(2), data_width'(rti_q.size()));
    $display("Test 4 finished: read burst, errors so far %0d", error_count);

    // Test 5, fill count
    preload_rti(5);
    read_burst(ctrl_addr, 0);
    compare("read beats", data_width'(1), data_width'(beats_seen));
    $display("Test 5 finished: fill count read, errors so far %0d", error_count);

    // Test 6, unmapped read and empty FIFO read
    read_burst(6'h20, 0);
    compare("read beats", data_width'(1), data_width'(beats_seen));
    preload_rti(0);
    read_burst(fifo_addr, 2);
    compare("read beats", data_width'(3), data_width'(beats_seen));
    $display("Test 6 finished: error reads, errors so far %0d", error_count);
endtask

// ==== verif/axi_fifo_bridge_tb.sv ====
`timescale 1ns/1ns

module axi_fifo_bridge_tb
    import axi_fifo_pkg::*;
();

    // Run limit sized for 40 bursts of 16 beats with stalls
    localparam int count_width     = 10;
    localparam int max_bursts      = 40;
    localparam int max_beats       = 16;
    localparam int cycles_per_beat = 6;
    localparam int cycle_limit     = max_bursts * max_beats * cycles_per_beat + 160;

    logic                   s_axi_aclk = 1'b0;
    logic                   s_axi_aresetn;
    logic [addr_width-1:0]  s_axi_awaddr;
    logic [id_width-1:0]    s_axi_awid;
    logic [7:0]             s_axi_awlen;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [data_width-1:0]  s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_wlast;
    logic                   s_axi_wready;
    logic                   s_axi_bready;
    logic                   s_axi_bvalid;
    logic [1:0]             s_axi_bresp;
    logic [id_width-1:0]    s_axi_bid;
    logic [addr_width-1:0]  s_axi_araddr;
    logic [id_width-1:0]    s_axi_arid;
    logic [7:0]             s_axi_arlen;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic                   s_axi_rready;
    logic                   s_axi_rvalid;
    logic [data_width-1:0]  s_axi_rdata;
    logic [1:0]             s_axi_rresp;
    logic                   s_axi_rlast;
    logic [id_width-1:0]    s_axi_rid;
    logic                   rto_core_reset;
    logic                   rto_core_flush;
    logic                   rto_core_write;
    logic [data_width-1:0]  rto_core_fifo_din;
    logic                   rto_core_full;
    logic                   rti_core_reset;
    logic                   rti_core_flush;
    logic                   rti_core_rd_en;
    logic [data_width-1:0]  rti_core_fifo_dout;
    logic                   rti_core_empty;
    logic [count_width-1:0] data_num;

    // FIFO core models and write beat list
    logic [data_width-1:0]  rto_q[$];
    logic [data_width-1:0]  rti_q[$];
    logic [data_width-1:0]  wr_data[$];

    integer                 seed = 86;
    int                     cycles = 0;
    int                     pass_count = 0;
    int                     error_count = 0;
    int                     beats_seen = 0;
    int                     exp_rlen = 0;
    logic [addr_width-1:0]  exp_waddr;
    logic [addr_width-1:0]  exp_raddr;
    logic [id_width-1:0]    exp_bid;
    logic [id_width-1:0]    exp_rid;
    logic [data_width+1:0]  expected;
    logic [data_width-1:0]  head;
    logic                   exp_rlast;

    axi_fifo_bridge #(
        .fifo_count_width (count_width)
    ) axi_fifo_bridge_i (.*);

    // 8 ns clock
    always #4 s_axi_aclk = ~s_axi_aclk;

    task automatic compare(input string name, input logic [data_width-1:0] exp_val,
                           input logic [data_width-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic logic [data_width-1:0] random_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the address map
    ////////////////////////////////////////////////////////////////////////////

    // Returns {resp, data} for one beat or one write response
    function automatic logic [data_width+1:0] ref_response(input logic is_write,
        input logic [addr_width-1:0] addr, input int count, input logic [data_width-1:0] top);
        logic [1:0]            resp;
        logic [data_width-1:0] data;
        resp = resp_slverr;
        data = '0;
        if (is_write) begin
            if ((addr == fifo_addr) || (addr == ctrl_addr)) begin
                resp = resp_okay;
            end
        end else if (addr == fifo_addr) begin
            // Empty FIFO gives zero data and slverr
            if (count > 0) begin
                resp = resp_okay;
                data = top;
            end
        end else if (addr == ctrl_addr) begin
            resp = resp_okay;
            data = data_width'(count);
        end
        return {resp, data};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // FIFO core models
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge s_axi_aclk) begin
        if (rto_core_flush) begin
            rto_q.delete();
        end
        if (rto_core_write) begin
            rto_q.push_back(rto_core_fifo_din);
        end
        if (rti_core_flush) begin
            rti_q.delete();
        end else if (rti_core_rd_en) begin
            // Pops only ever take a stored word
            if (rti_q.size() > 0) begin
                rti_q.delete(0);
            end else begin
                compare("rti_core_rd_en", '0, data_width'(rti_core_rd_en));
            end
        end
        // FWFT view of the queue head
        rti_core_empty     <= (rti_q.size() == 0);
        rti_core_fifo_dout <= (rti_q.size() > 0) ? rti_q[0] : '0;
        data_num           <= count_width'(rti_q.size());
        // Full about one cycle in four
        rto_core_full      <= (($random(seed) & 3) == 0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response checker sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge s_axi_aclk) begin
        if (s_axi_aresetn && s_axi_rvalid && s_axi_rready) begin
            head      = (rti_q.size() > 0) ? rti_q[0] : '0;
            expected  = ref_response(1'b0, exp_raddr, rti_q.size(), head);
            // Only FIFO reads run past one beat
            exp_rlast = (exp_raddr != fifo_addr) || (beats_seen == exp_rlen);
            compare("s_axi_rdata", expected[data_width-1:0], s_axi_rdata);
            compare("s_axi_rresp", data_width'(expected[data_width+1:data_width]),
                    data_width'(s_axi_rresp));
            compare("s_axi_rlast", data_width'(exp_rlast), data_width'(s_axi_rlast));
            compare("s_axi_rid", data_width'(exp_rid), data_width'(s_axi_rid));
            beats_seen++;
        end
        if (s_axi_aresetn && s_axi_bvalid && s_axi_bready) begin
            expected = ref_response(1'b1, exp_waddr, 0, '0);
            compare("s_axi_bresp", data_width'(expected[data_width+1:data_width]),
                    data_width'(s_axi_bresp));
            compare("s_axi_bid", data_width'(exp_bid), data_width'(s_axi_bid));
        end
        // Payload beats stall on a full rto FIFO, flush and discard beats never
        if (s_axi_aresetn && s_axi_wvalid) begin
            compare("s_axi_wready",
                    data_width'((exp_waddr != fifo_addr) || !rto_core_full),
                    data_width'(s_axi_wready));
        end
        // No new address while a burst is open
        if (s_axi_aresetn && (s_axi_wvalid || s_axi_bvalid)) begin
            compare("s_axi_awready", '0, data_width'(s_axi_awready));
        end
        if (s_axi_aresetn && s_axi_rvalid) begin
            compare("s_axi_arready", '0, data_width'(s_axi_arready));
        end
    end

    // Hang guard
    always @(posedge s_axi_aclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, test sequence did not finish", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    `include "axi_fifo_bridge_tests.svh"

    initial begin
        s_axi_aresetn      <= 1'b0;
        s_axi_awaddr       <= '0;
        s_axi_awid         <= '0;
        s_axi_awlen        <= '0;
        s_axi_awvalid      <= 1'b0;
        s_axi_wdata        <= '0;
        s_axi_wvalid       <= 1'b0;
        s_axi_wlast        <= 1'b0;
        s_axi_bready       <= 1'b0;
        s_axi_araddr       <= '0;
        s_axi_arid         <= '0;
        s_axi_arlen        <= '0;
        s_axi_arvalid      <= 1'b0;
        s_axi_rready       <= 1'b0;
        rto_core_full      <= 1'b0;
        rti_core_fifo_dout <= '0;
        rti_core_empty     <= 1'b1;
        data_num           <= '0;
        run_tests();
        $display("Checks passed %0d, errors %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
